//--- sources.f
rtl/rs_pkg.sv
rtl/rs_fill_if.sv
rtl/rs_dispatch.sv
rtl/rs_entry_array.sv
rtl/rs_issue_select.sv
rtl/rs_top.sv
bench/rs_asserts.sv
bench/rs_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the reservation station testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sources.f --top-module rs_tb -o rs_sim \
   && ./obj_dir/rs_sim 2>&1 | tee sim.log \
   || { echo "build or simulation did not complete"; exit 1; }

grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

//--- bench/rs_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the reservation station, a stimulus table is applied
// cycle by cycle and every output is compared with a reference model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rs_tb;
   import rs_pkg::*;

   localparam int DRAIN_LIMIT = 40;

   typedef struct packed
   {
      logic         valid;
      rs_tag_t      dest_tag;
      rs_alu_func_t alu_func;
      rs_tag_t      tag_a;
      rs_value_t    value_a;
      rs_tag_t      tag_b;
      rs_value_t    value_b;
      rs_tag_t      cdb_tag;
      rs_value_t    cdb_value;
   } step_t;

   logic         clock = 1'b0;
   logic         reset;
   logic         dispatch_valid;
   rs_tag_t      dispatch_dest_tag;
   rs_alu_func_t dispatch_alu_func;
   rs_tag_t      dispatch_tag_a;
   rs_value_t    dispatch_value_a;
   rs_tag_t      dispatch_tag_b;
   rs_value_t    dispatch_value_b;
   rs_tag_t      cdb_tag;
   rs_value_t    cdb_value;
   logic         dispatch_ready;
   logic         issue_valid;
   rs_tag_t      issue_dest_tag;
   rs_alu_func_t issue_alu_func;
   rs_value_t    issue_value_a;
   rs_value_t    issue_value_b;

   step_t table_q [$];
   step_t applied;

   // reference model of the entries
   logic         model_busy    [RS_ENTRIES];
   rs_tag_t      model_tag_a   [RS_ENTRIES];
   rs_tag_t      model_tag_b   [RS_ENTRIES];
   rs_value_t    model_value_a [RS_ENTRIES];
   rs_value_t    model_value_b [RS_ENTRIES];
   rs_tag_t      model_dest    [RS_ENTRIES];
   rs_alu_func_t model_func    [RS_ENTRIES];
   rs_age_t      model_age     [RS_ENTRIES];

   // expected issue outputs after the latest edge
   logic         exp_valid;
   rs_tag_t      exp_dest_tag;
   rs_alu_func_t exp_alu_func;
   rs_value_t    exp_value_a;
   rs_value_t    exp_value_b;

   int          accepted_count = 0;
   int          issued_count = 0;
   int          wait_cycles;
   int unsigned seed;
   bit          verdict_printed = 1'b0;

   rs_top rs_top_inst (
      .clock             (clock),
      .reset             (reset),
      .dispatch_valid    (dispatch_valid),
      .dispatch_dest_tag (dispatch_dest_tag),
      .dispatch_alu_func (dispatch_alu_func),
      .dispatch_tag_a    (dispatch_tag_a),
      .dispatch_value_a  (dispatch_value_a),
      .dispatch_tag_b    (dispatch_tag_b),
      .dispatch_value_b  (dispatch_value_b),
      .cdb_tag           (cdb_tag),
      .cdb_value         (cdb_value),
      .dispatch_ready    (dispatch_ready),
      .issue_valid       (issue_valid),
      .issue_dest_tag    (issue_dest_tag),
      .issue_alu_func    (issue_alu_func),
      .issue_value_a     (issue_value_a),
      .issue_value_b     (issue_value_b)
   );

   always #50 clock = ~clock;

   task automatic abort_run(input string reason);
      verdict_printed = 1'b1;
      $display("TEST RESULT: FAIL");
      $fatal(1, "%s", reason);
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      assert (actual === expected)
      else
      begin
         $display("Mismatch at time %0t: %s expected %0h actual %0h",
                  $time, name, expected, actual);
         abort_run("output differs from the reference model");
      end
   endtask

   function automatic step_t idle_step();
      step_t s;
      s = '0;
      s.tag_a   = TAG_NULL;
      s.tag_b   = TAG_NULL;
      s.cdb_tag = TAG_NULL;
      return s;
   endfunction

   task automatic add_row(input logic valid, input rs_tag_t dest_tag,
                          input rs_alu_func_t alu_func, input rs_tag_t tag_a,
                          input rs_tag_t tag_b, input rs_tag_t cdb_tag);
      step_t s;
      s.valid     = valid;
      s.dest_tag  = dest_tag;
      s.alu_func  = alu_func;
      s.tag_a     = tag_a;
      s.value_a   = {$urandom, $urandom};
      s.tag_b     = tag_b;
      s.value_b   = {$urandom, $urandom};
      s.cdb_tag   = cdb_tag;
      s.cdb_value = {$urandom, $urandom};
      table_q.push_back(s);
   endtask

   task automatic add_idle(input int count);
      for (int i = 0; i < count; i++)
         add_row(1'b0, 8'h00, 5'h00, TAG_NULL, TAG_NULL, TAG_NULL);
   endtask

   task automatic build_table();
      // ready instruction
      add_row(1'b1, 8'h01, 5'h03, TAG_NULL, TAG_NULL, TAG_NULL);
      add_idle(3);
      // a waits on tag 10, b takes the broadcast of tag 11 in the same cycle
      add_row(1'b1, 8'h02, 5'h07, 8'h10, 8'h11, 8'h11);
      add_idle(4);
      add_row(1'b0, 8'h00, 5'h00, TAG_NULL, TAG_NULL, 8'h10);
      add_idle(3);
      // three entries become ready at one edge
      add_row(1'b1, 8'h03, 5'h01, 8'h20, TAG_NULL, TAG_NULL);
      add_row(1'b1, 8'h04, 5'h02, TAG_NULL, 8'h20, TAG_NULL);
      add_row(1'b1, 8'h05, 5'h04, 8'h21, 8'h20, TAG_NULL);
      add_row(1'b0, 8'h00, 5'h00, TAG_NULL, TAG_NULL, 8'h21);
      add_row(1'b0, 8'h00, 5'h00, TAG_NULL, TAG_NULL, 8'h20);
      add_idle(5);
      // fill all entries, offer more while full, then release entry 3
      for (int i = 0; i < RS_ENTRIES; i++)
         add_row(1'b1, rs_tag_t'(8'h40 + i), rs_alu_func_t'(i),
                 rs_tag_t'(8'h30 + i), TAG_NULL, TAG_NULL);
      add_row(1'b1, 8'h50, 5'h1f, TAG_NULL, TAG_NULL, TAG_NULL);
      add_row(1'b1, 8'h51, 5'h1e, TAG_NULL, TAG_NULL, 8'h33);
      add_row(1'b1, 8'h52, 5'h1d, TAG_NULL, TAG_NULL, TAG_NULL);
      // refill of entry 3 is younger than the higher entries and shares tag 34
      add_row(1'b1, 8'h53, 5'h1c, 8'h34, TAG_NULL, TAG_NULL);
      for (int i = 0; i < RS_ENTRIES; i++)
         add_row(1'b0, 8'h00, 5'h00, TAG_NULL, TAG_NULL, rs_tag_t'(8'h30 + i));
   endtask

   task automatic clear_model();
      for (int i = 0; i < RS_ENTRIES; i++)
      begin
         model_busy[i]  = 1'b0;
         model_tag_a[i] = TAG_NULL;
         model_tag_b[i] = TAG_NULL;
         model_age[i]   = '0;
      end
      exp_valid = 1'b0;
   endtask

   function automatic logic model_has_room();
      logic room;
      room = 1'b0;
      for (int i = 0; i < RS_ENTRIES; i++)
         if (!model_busy[i])
            room = 1'b1;
      return room;
   endfunction

   // one clock edge of the station, with the inputs of the cycle before it
   task automatic model_edge(input step_t s);
      int   win;
      int   slot;
      logic hit_a;
      logic hit_b;
      win  = -1;
      slot = -1;
      // oldest ready entry, lowest index on equal age
      for (int i = 0; i < RS_ENTRIES; i++)
         if (model_busy[i] && (model_tag_a[i] == TAG_NULL) && (model_tag_b[i] == TAG_NULL))
            if ((win < 0) || (model_age[i] > model_age[win]))
               win = i;
      // lowest empty entry before this edge
      for (int i = RS_ENTRIES - 1; i >= 0; i--)
         if (!model_busy[i])
            slot = i;
      if (!s.valid)
         slot = -1;
      exp_valid = (win >= 0);
      if (win >= 0)
      begin
         exp_dest_tag     = model_dest[win];
         exp_alu_func     = model_func[win];
         exp_value_a      = model_value_a[win];
         exp_value_b      = model_value_b[win];
         model_busy[win]  = 1'b0;
      end
      for (int i = 0; i < RS_ENTRIES; i++)
      begin
         if (model_busy[i] && (s.cdb_tag != TAG_NULL))
         begin
            if (model_tag_a[i] == s.cdb_tag)
            begin
               model_tag_a[i]   = TAG_NULL;
               model_value_a[i] = s.cdb_value;
            end
            if (model_tag_b[i] == s.cdb_tag)
            begin
               model_tag_b[i]   = TAG_NULL;
               model_value_b[i] = s.cdb_value;
            end
         end
         if (model_busy[i] && (slot >= 0) && (model_age[i] != AGE_MAX))
            model_age[i] = model_age[i] + 8'd1;
      end
      if (slot >= 0)
      begin
         hit_a = (s.cdb_tag != TAG_NULL) && (s.tag_a == s.cdb_tag);
         hit_b = (s.cdb_tag != TAG_NULL) && (s.tag_b == s.cdb_tag);
         model_busy[slot]    = 1'b1;
         model_tag_a[slot]   = hit_a ? TAG_NULL : s.tag_a;
         model_value_a[slot] = hit_a ? s.cdb_value : s.value_a;
         model_tag_b[slot]   = hit_b ? TAG_NULL : s.tag_b;
         model_value_b[slot] = hit_b ? s.cdb_value : s.value_b;
         model_dest[slot]    = s.dest_tag;
         model_func[slot]    = s.alu_func;
         model_age[slot]     = '0;
         accepted_count++;
      end
   endtask

   task automatic drive_inputs(input step_t s);
      dispatch_valid    <= s.valid;
      dispatch_dest_tag <= s.dest_tag;
      dispatch_alu_func <= s.alu_func;
      dispatch_tag_a    <= s.tag_a;
      dispatch_value_a  <= s.value_a;
      dispatch_tag_b    <= s.tag_b;
      dispatch_value_b  <= s.value_b;
      cdb_tag           <= s.cdb_tag;
      cdb_value         <= s.cdb_value;
   endtask

   task automatic compare_outputs();
      check_value("issue_valid", 64'(issue_valid), 64'(exp_valid));
      if (exp_valid)
      begin
         check_value("issue_dest_tag", 64'(issue_dest_tag), 64'(exp_dest_tag));
         check_value("issue_alu_func", 64'(issue_alu_func), 64'(exp_alu_func));
         check_value("issue_value_a", issue_value_a, exp_value_a);
         check_value("issue_value_b", issue_value_b, exp_value_b);
      end
      check_value("dispatch_ready", 64'(dispatch_ready), 64'(model_has_room()));
      if (issue_valid)
         issued_count++;
   endtask

   // drive at the rising edge, compare at the falling edge
   task automatic run_cycle(input step_t next);
      @(posedge clock);
      model_edge(applied);
      applied = next;
      drive_inputs(next);
      @(negedge clock);
      compare_outputs();
   endtask

   initial
   begin
      seed = $urandom(32'hf5c5);
      reset <= 1'b1;
      applied = idle_step();
      drive_inputs(applied);
      clear_model();
      build_table();
      repeat (16) @(posedge clock);
      reset <= 1'b0;
      @(negedge clock);
      check_value("issue_valid", 64'(issue_valid), 64'd0);
      check_value("dispatch_ready", 64'(dispatch_ready), 64'd1);
      foreach (table_q[k])
         run_cycle(table_q[k]);
      // let every accepted entry issue
      wait_cycles = 0;
      while (issued_count < accepted_count)
      begin
         if (wait_cycles >= DRAIN_LIMIT)
            abort_run("timeout waiting for issue_valid of the remaining entries");
         else
         begin
            run_cycle(idle_step());
            wait_cycles++;
         end
      end
      if (issued_count == accepted_count)
      begin
         verdict_printed = 1'b1;
         $display("TEST RESULT: PASS");
         $finish;
      end
      else
         abort_run("number of issued entries differs from accepted dispatches");
   end

   final
   begin
      if (!verdict_printed)
         $display("TEST RESULT: FAIL");
   end

endmodule

//--- bench/rs_asserts.sv
////////////////////////////////////////////////////////////////////////////
// concurrent checks on the entry array, attached by bind
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rs_asserts (
   input logic               clock,
   input logic               reset,
   input logic               fill,
   input rs_pkg::rs_status_e fill_status,
   input logic               grant,
   input rs_pkg::rs_status_e grant_status,
   input logic               issue_valid
);
   import rs_pkg::*;

   // a new instruction never lands on a live entry
   fill_into_empty: assert property (@(posedge clock) disable iff (reset)
      fill |-> (fill_status == RS_EMPTY))
      else $error("fill targeted an entry that is not empty");

   grant_of_ready: assert property (@(posedge clock) disable iff (reset)
      grant |-> (grant_status == RS_READY))
      else $error("grant selected an entry that is not ready");

   // nothing issues in the first cycle out of reset
   quiet_after_reset: assert property (@(posedge clock)
      $fell(reset) |-> !issue_valid)
      else $error("issue_valid high in the first cycle after reset");

endmodule

bind rs_entry_array rs_asserts rs_asserts_inst (
   .clock        (clock),
   .reset        (reset),
   .fill         (fill_bus.fill),
   .fill_status  (status_q[fill_bus.fill_index]),
   .grant        (grant),
   .grant_status (status_q[grant_index]),
   .issue_valid  (issue_valid)
);

//--- rtl/rs_top.sv
////////////////////////////////////////////////////////////////////////////
// reservation station top level, dispatch, entry array and issue select
// one dispatch, one CDB and one issue per cycle, all on plain ports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rs_top (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 dispatch_valid,
   input  rs_pkg::rs_tag_t      dispatch_dest_tag,
   input  rs_pkg::rs_alu_func_t dispatch_alu_func,
   input  rs_pkg::rs_tag_t      dispatch_tag_a,
   input  rs_pkg::rs_value_t    dispatch_value_a,
   input  rs_pkg::rs_tag_t      dispatch_tag_b,
   input  rs_pkg::rs_value_t    dispatch_value_b,
   input  rs_pkg::rs_tag_t      cdb_tag,
   input  rs_pkg::rs_value_t    cdb_value,
   output logic                 dispatch_ready,
   output logic                 issue_valid,
   output rs_pkg::rs_tag_t      issue_dest_tag,
   output rs_pkg::rs_alu_func_t issue_alu_func,
   output rs_pkg::rs_value_t    issue_value_a,
   output rs_pkg::rs_value_t    issue_value_b
);
   import rs_pkg::*;

   logic [RS_ENTRIES-1:0]          empty_mask;
   logic [RS_ENTRIES-1:0]          ready_mask;
   rs_age_t [RS_ENTRIES-1:0]       ages;
   logic                           grant;
   rs_index_t                      grant_index;

   rs_fill_if fill_bus ();

   rs_dispatch rs_dispatch_inst (
      .dispatch_valid    (dispatch_valid),
      .dispatch_dest_tag (dispatch_dest_tag),
      .dispatch_alu_func (dispatch_alu_func),
      .dispatch_tag_a    (dispatch_tag_a),
      .dispatch_value_a  (dispatch_value_a),
      .dispatch_tag_b    (dispatch_tag_b),
      .dispatch_value_b  (dispatch_value_b),
      .cdb_tag           (cdb_tag),
      .cdb_value         (cdb_value),
      .empty_mask        (empty_mask),
      .dispatch_ready    (dispatch_ready),
      .fill_bus          (fill_bus.dispatch_side)
   );

   rs_entry_array rs_entry_array_inst (
      .clock          (clock),
      .reset          (reset),
      .cdb_tag        (cdb_tag),
      .cdb_value      (cdb_value),
      .grant          (grant),
      .grant_index    (grant_index),
      .fill_bus       (fill_bus.array_side),
      .empty_mask     (empty_mask),
      .ready_mask     (ready_mask),
      .ages           (ages),
      .issue_valid    (issue_valid),
      .issue_dest_tag (issue_dest_tag),
      .issue_alu_func (issue_alu_func),
      .issue_value_a  (issue_value_a),
      .issue_value_b  (issue_value_b)
   );

   rs_issue_select rs_issue_select_inst (
      .ready_mask  (ready_mask),
      .ages        (ages),
      .grant       (grant),
      .grant_index (grant_index)
   );

endmodule

//--- rtl/rs_issue_select.sv
////////////////////////////////////////////////////////////////////////////
// issue select, grants the oldest ready entry
// equal ages resolve toward the lower index
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rs_issue_select (
   input  logic [rs_pkg::RS_ENTRIES-1:0]            ready_mask,
   input  rs_pkg::rs_age_t [rs_pkg::RS_ENTRIES-1:0] ages,
   output logic                                     grant,
   output rs_pkg::rs_index_t                        grant_index
);
   import rs_pkg::*;

   // beats[j][i] set when ready entry j is chosen ahead of entry i
   logic [RS_ENTRIES-1:0] beats [RS_ENTRIES];
   logic [RS_ENTRIES-1:0] winner;

   always_comb
   begin
      for (int j = 0; j < RS_ENTRIES; j++)
      begin
         for (int i = 0; i < RS_ENTRIES; i++)
         begin
            beats[j][i] = ready_mask[j] && (j != i)
                          && ((ages[j] > ages[i]) || ((ages[j] == ages[i]) && (j < i)));
         end
      end
   end

   // a ready entry that nobody beats, at most one such entry
   always_comb
   begin
      for (int i = 0; i < RS_ENTRIES; i++)
      begin
         winner[i] = ready_mask[i];
         for (int j = 0; j < RS_ENTRIES; j++)
         begin
            if (beats[j][i])
               winner[i] = 1'b0;
         end
      end
   end

   // one-hot to index
   always_comb
   begin
      grant_index = '0;
      for (int i = 0; i < RS_ENTRIES; i++)
      begin
         if (winner[i])
            grant_index = grant_index | rs_index_t'(i);
      end
   end

   assign grant = |ready_mask;

endmodule

//--- rtl/rs_entry_array.sv
////////////////////////////////////////////////////////////////////////////
// entry storage with status, age and CDB wakeup per entry
// a grant frees its entry and registers it onto the issue outputs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rs_entry_array (
   input  logic                                  clock,
   input  logic                                  reset,
   input  rs_pkg::rs_tag_t                       cdb_tag,
   input  rs_pkg::rs_value_t                     cdb_value,
   input  logic                                  grant,
   input  rs_pkg::rs_index_t                     grant_index,
   rs_fill_if.array_side                         fill_bus,
   output logic [rs_pkg::RS_ENTRIES-1:0]         empty_mask,
   output logic [rs_pkg::RS_ENTRIES-1:0]         ready_mask,
   output rs_pkg::rs_age_t [rs_pkg::RS_ENTRIES-1:0] ages,
   output logic                                  issue_valid,
   output rs_pkg::rs_tag_t                       issue_dest_tag,
   output rs_pkg::rs_alu_func_t                  issue_alu_func,
   output rs_pkg::rs_value_t                     issue_value_a,
   output rs_pkg::rs_value_t                     issue_value_b
);
   import rs_pkg::*;

   rs_status_e   status_q   [RS_ENTRIES];
   rs_tag_t      tag_a_q    [RS_ENTRIES];
   rs_tag_t      tag_b_q    [RS_ENTRIES];
   rs_value_t    value_a_q  [RS_ENTRIES];
   rs_value_t    value_b_q  [RS_ENTRIES];
   rs_tag_t      dest_tag_q [RS_ENTRIES];
   rs_alu_func_t alu_func_q [RS_ENTRIES];
   rs_age_t      age_q      [RS_ENTRIES];

   logic [RS_ENTRIES-1:0] write_sel;
   logic [RS_ENTRIES-1:0] grant_sel;
   logic [RS_ENTRIES-1:0] wake_a;
   logic [RS_ENTRIES-1:0] wake_b;

   // state follows from which operand tags are still outstanding
   function automatic rs_status_e status_from_tags(input rs_tag_t tag_a, input rs_tag_t tag_b);
      logic wait_a;
      logic wait_b;
      wait_a = (tag_a != TAG_NULL);
      wait_b = (tag_b != TAG_NULL);
      case ({wait_a, wait_b})
         2'b00:   return RS_READY;
         2'b01:   return RS_WAITING_B;
         2'b10:   return RS_WAITING_A;
         default: return RS_WAITING_BOTH;
      endcase
   endfunction

   always_comb
   begin
      for (int i = 0; i < RS_ENTRIES; i++)
      begin
         write_sel[i]  = fill_bus.fill && (fill_bus.fill_index == rs_index_t'(i));
         grant_sel[i]  = grant && (grant_index == rs_index_t'(i));
         wake_a[i]     = (status_q[i] != RS_EMPTY) && (tag_a_q[i] != TAG_NULL)
                         && (tag_a_q[i] == cdb_tag);
         wake_b[i]     = (status_q[i] != RS_EMPTY) && (tag_b_q[i] != TAG_NULL)
                         && (tag_b_q[i] == cdb_tag);
         empty_mask[i] = (status_q[i] == RS_EMPTY);
         ready_mask[i] = (status_q[i] == RS_READY);
         ages[i]       = age_q[i];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // status, waiting tags and ages
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         for (int i = 0; i < RS_ENTRIES; i++)
         begin
            status_q[i] <= RS_EMPTY;
            tag_a_q[i]  <= TAG_NULL;
            tag_b_q[i]  <= TAG_NULL;
            age_q[i]    <= '0;
         end
         issue_valid <= 1'b0;
      end
      else
      begin
         for (int i = 0; i < RS_ENTRIES; i++)
         begin
            if (write_sel[i])
            begin
               tag_a_q[i]  <= fill_bus.tag_a;
               tag_b_q[i]  <= fill_bus.tag_b;
               status_q[i] <= status_from_tags(fill_bus.tag_a, fill_bus.tag_b);
               age_q[i]    <= '0;
            end
            else if (grant_sel[i])
            begin
               status_q[i] <= RS_EMPTY;
            end
            else if (status_q[i] != RS_EMPTY)
            begin
               if (wake_a[i])
                  tag_a_q[i] <= TAG_NULL;
               if (wake_b[i])
                  tag_b_q[i] <= TAG_NULL;
               status_q[i] <= status_from_tags(wake_a[i] ? TAG_NULL : tag_a_q[i],
                                               wake_b[i] ? TAG_NULL : tag_b_q[i]);
               // each accepted dispatch makes the older entries one step older
               if (fill_bus.fill && (age_q[i] != AGE_MAX))
                  age_q[i] <= age_q[i] + 1'b1;
            end
         end
         issue_valid <= grant;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // operand values, entry fields and issue payload
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock)
   begin
      for (int i = 0; i < RS_ENTRIES; i++)
      begin
         if (write_sel[i])
         begin
            value_a_q[i]  <= fill_bus.value_a;
            value_b_q[i]  <= fill_bus.value_b;
            dest_tag_q[i] <= fill_bus.dest_tag;
            alu_func_q[i] <= fill_bus.alu_func;
         end
         else
         begin
            if (wake_a[i])
               value_a_q[i] <= cdb_value;
            if (wake_b[i])
               value_b_q[i] <= cdb_value;
         end
      end
      if (grant)
      begin
         issue_dest_tag <= dest_tag_q[grant_index];
         issue_alu_func <= alu_func_q[grant_index];
         issue_value_a  <= value_a_q[grant_index];
         issue_value_b  <= value_b_q[grant_index];
      end
   end

endmodule

//--- rtl/rs_dispatch.sv
////////////////////////////////////////////////////////////////////////////
// dispatch stage, picks the lowest empty entry and resolves operands
// that are broadcast on the CDB in the dispatch cycle itself
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rs_dispatch (
   input  logic                          dispatch_valid,
   input  rs_pkg::rs_tag_t               dispatch_dest_tag,
   input  rs_pkg::rs_alu_func_t          dispatch_alu_func,
   input  rs_pkg::rs_tag_t               dispatch_tag_a,
   input  rs_pkg::rs_value_t             dispatch_value_a,
   input  rs_pkg::rs_tag_t               dispatch_tag_b,
   input  rs_pkg::rs_value_t             dispatch_value_b,
   input  rs_pkg::rs_tag_t               cdb_tag,
   input  rs_pkg::rs_value_t             cdb_value,
   input  logic [rs_pkg::RS_ENTRIES-1:0] empty_mask,
   output logic                          dispatch_ready,
   rs_fill_if.dispatch_side              fill_bus
);
   import rs_pkg::*;

   rs_index_t free_index;
   logic      free_found;
   logic      match_a;
   logic      match_b;

   // priority search, lowest index wins
   always_comb
   begin
      free_index = '0;
      free_found = 1'b0;
      for (int i = RS_ENTRIES - 1; i >= 0; i--)
      begin
         if (empty_mask[i])
         begin
            free_index = rs_index_t'(i);
            free_found = 1'b1;
         end
      end
   end

   // result already on the CDB this cycle, take it now
   assign match_a = (cdb_tag != TAG_NULL) && (dispatch_tag_a == cdb_tag);
   assign match_b = (cdb_tag != TAG_NULL) && (dispatch_tag_b == cdb_tag);

   assign dispatch_ready      = free_found;
   assign fill_bus.fill       = dispatch_valid && free_found;
   assign fill_bus.fill_index = free_index;
   assign fill_bus.dest_tag   = dispatch_dest_tag;
   assign fill_bus.alu_func   = dispatch_alu_func;
   assign fill_bus.tag_a      = match_a ? TAG_NULL : dispatch_tag_a;
   assign fill_bus.value_a    = match_a ? cdb_value : dispatch_value_a;
   assign fill_bus.tag_b      = match_b ? TAG_NULL : dispatch_tag_b;
   assign fill_bus.value_b    = match_b ? cdb_value : dispatch_value_b;

endmodule

//--- rtl/rs_fill_if.sv
////////////////////////////////////////////////////////////////////////////
// one entry write, carried from dispatch into the entry array
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface rs_fill_if;
   import rs_pkg::*;

   logic         fill;
   rs_index_t    fill_index;
   rs_tag_t      dest_tag;
   rs_alu_func_t alu_func;
   rs_tag_t      tag_a;
   rs_value_t    value_a;
   rs_tag_t      tag_b;
   rs_value_t    value_b;

   modport dispatch_side (output fill, fill_index, dest_tag, alu_func,
                          tag_a, value_a, tag_b, value_b);

   modport array_side (input fill, fill_index, dest_tag, alu_func,
                       tag_a, value_a, tag_b, value_b);

endinterface

//--- rtl/rs_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared widths, types and constants for the reservation station
// imported by every RTL block and by the testbench
////////////////////////////////////////////////////////////////////////////

package rs_pkg;

   // number of station entries
   localparam int RS_ENTRIES = 8;

   // payload and bookkeeping widths
   typedef logic [7:0]  rs_tag_t;
   typedef logic [63:0] rs_value_t;
   typedef logic [4:0]  rs_alu_func_t;
   typedef logic [$clog2(RS_ENTRIES)-1:0] rs_index_t;
   typedef logic [7:0]  rs_age_t;

   // tag meaning "not waiting" on an operand, or "no broadcast" on the CDB
   localparam rs_tag_t TAG_NULL = 8'hff;

   // ages stop counting here
   localparam rs_age_t AGE_MAX = 8'd255;

   // per entry state
   typedef enum logic [2:0]
   {
      RS_EMPTY        = 3'b000,
      RS_WAITING_A    = 3'b001,
      RS_WAITING_B    = 3'b010,
      RS_WAITING_BOTH = 3'b011,
      RS_READY        = 3'b100
   } rs_status_e;

endpackage
